//--- eth_mac_macros.svh
`ifndef ETH_MAC_MACROS_SVH
`define ETH_MAC_MACROS_SVH

// Frame layout
`define ETH_PREAMBLE_LEN   8                  // Seven preamble bytes plus SFD
`define ETH_PREAMBLE_BYTE  8'h55
`define ETH_SFD            8'hD5
`define ETH_MIN_PAYLOAD    46                 // Shorter payloads get zero padding
`define ETH_IFG            12                 // Idle cycles after each frame

// Transmit buffer, 2**AW bytes
`define ETH_FIFO_AW        7

// Register value left after folding in a good FCS
`define ETH_CRC_RESIDUE    32'hDEBB20E3

`define ETH_BCAST          48'hFFFF_FFFF_FFFF

`endif

//--- eth_mac_pkg.sv
`default_nettype none

package eth_mac_pkg;

  //////////////////////////////////////////////////
  // PHY side
  //////////////////////////////////////////////////

  // One byte per cycle, val high for the whole frame
  typedef struct packed {
    logic [7:0] dat;
    logic       val;
  } phy_t;

  //////////////////////////////////////////////////
  // Frame header and user side
  //////////////////////////////////////////////////

  typedef struct packed {
    logic [47:0] dst;
    logic [47:0] src;
    logic [15:0] ethertype; // Passed through untouched
  } mac_hdr_t;

  // Source address is not part of a request, it comes from loc_mac
  typedef struct packed {
    logic [47:0] dst;
    logic [15:0] ethertype;
  } tx_req_t;

  // Valid in the cycle rx_done is high
  typedef struct packed {
    mac_hdr_t hdr;
    logic     fcs_ok;
    logic     bcast;
  } rx_status_t;

endpackage

`default_nettype wire

//--- eth_crc32.sv
`default_nettype none

module eth_crc32 (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        clr,
  input  logic        en,
  input  logic [7:0]  din,
  output logic [31:0] crc
);

  localparam logic [31:0] POLY = 32'hEDB88320; // Reflected 0x04C11DB7

  logic [31:0] crc_nxt;

  // One byte, LSB first
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ POLY) : (r >> 1);
    end
    return r;
  endfunction

  assign crc_nxt = crc_step(crc, din);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      crc <= '1;
    end else if (clr) begin
      crc <= '1;                  // Clear wins over enable
    end else if (en) begin
      crc <= crc_nxt;
    end
  end

endmodule

`default_nettype wire

//--- eth_tx_fifo.sv
`default_nettype none
`include "eth_mac_macros.svh"

module eth_tx_fifo (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr,
  input  logic [7:0]             wdata,
  input  logic                   rd,
  output logic [7:0]             rdata,
  output logic [`ETH_FIFO_AW:0]  count
);

  localparam int AW    = `ETH_FIFO_AW;
  localparam int DEPTH = 1 << AW;

  logic [7:0]    mem [DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          full;
  logic          empty;
  logic          wr_ok;
  logic          rd_ok;

  assign full  = (count == (AW + 1)'(DEPTH));
  assign empty = (count == '0);
  assign wr_ok = wr && !full;   // Writes into a full buffer are lost
  assign rd_ok = rd && !empty;

  assign rdata = mem[rd_ptr];   // Head byte visible without a read

  always_ff @(posedge clk) begin
    if (wr_ok) mem[wr_ptr] <= wdata;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok) rd_ptr <= rd_ptr + 1'b1;
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // User side has no back-pressure
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) wr |-> !full)
    else $error("eth_tx_fifo: write while full, byte dropped");

  // The frame builder reads only what it latched at send time
  a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) rd |-> !empty)
    else $error("eth_tx_fifo: read while empty");

endmodule

`default_nettype wire

//--- eth_tx.sv
`default_nettype none
`include "eth_mac_macros.svh"

module eth_tx (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [7:0]           din,
  input  logic                 vin,
  input  logic                 snd,
  input  eth_mac_pkg::tx_req_t req,
  input  logic [47:0]          loc_mac,
  output logic                 cts,
  output eth_mac_pkg::phy_t    phy
);

  localparam int LW        = `ETH_FIFO_AW + 1;
  localparam int MIN_FRAME = `ETH_PREAMBLE_LEN + 14 + `ETH_MIN_PAYLOAD + 4;

  typedef enum logic [2:0] {S_IDLE, S_PRE, S_HDR, S_PAY, S_PAD, S_FCS, S_GAP} state_t;

  state_t                state;
  logic [3:0]            cnt;       // Preamble, header, FCS and gap steps
  logic [LW-1:0]         pay_cnt;   // Payload plus pad bytes sent
  logic [LW-1:0]         len;
  logic [LW-1:0]         fifo_count;
  eth_mac_pkg::mac_hdr_t hdr_sr;
  logic [7:0]            fifo_rdata;
  logic                  fifo_rd;
  logic [31:0]           crc;
  logic                  crc_en;
  logic [7:0]            tx_byte;

  eth_tx_fifo u_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .wr    (vin),
    .wdata (din),
    .rd    (fifo_rd),
    .rdata (fifo_rdata),
    .count (fifo_count)
  );

  eth_crc32 u_crc (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (state == S_IDLE),
    .en    (crc_en),
    .din   (tx_byte),
    .crc   (crc)
  );

  assign cts     = (state == S_IDLE);
  assign fifo_rd = (state == S_PAY);
  assign crc_en  = (state == S_HDR) || (state == S_PAY) || (state == S_PAD);

  //////////////////////////////////////////////////
  // Byte select
  //////////////////////////////////////////////////

  always_comb begin
    case (state)
      S_PRE:   tx_byte = (cnt == 4'(`ETH_PREAMBLE_LEN - 1)) ? `ETH_SFD : `ETH_PREAMBLE_BYTE;
      S_HDR:   tx_byte = hdr_sr[111:104];
      S_PAY:   tx_byte = fifo_rdata;
      S_FCS:   tx_byte = ~crc[{cnt[1:0], 3'b000} +: 8]; // Low byte first
      default: tx_byte = 8'h00;                          // Pad and idle
    endcase
  end

  assign phy = '{dat: tx_byte, val: (state != S_IDLE) && (state != S_GAP)};

  //////////////////////////////////////////////////
  // Frame FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      cnt     <= '0;
      pay_cnt <= '0;
    end else begin
      case (state)
        S_IDLE: if (snd) begin
          state <= S_PRE;
          cnt   <= '0;
        end
        S_PRE: if (cnt == 4'(`ETH_PREAMBLE_LEN - 1)) begin
          state <= S_HDR;
          cnt   <= '0;
        end else cnt <= cnt + 1'b1;
        S_HDR: if (cnt == 4'd13) begin
          state   <= (len == '0) ? S_PAD : S_PAY;
          cnt     <= '0;
          pay_cnt <= '0;
        end else cnt <= cnt + 1'b1;
        S_PAY: begin
          pay_cnt <= pay_cnt + 1'b1;
          if (pay_cnt == len - 1'b1) begin
            state <= (pay_cnt < LW'(`ETH_MIN_PAYLOAD - 1)) ? S_PAD : S_FCS;
          end
        end
        S_PAD: begin
          pay_cnt <= pay_cnt + 1'b1;
          if (pay_cnt == LW'(`ETH_MIN_PAYLOAD - 1)) state <= S_FCS;
        end
        S_FCS: if (cnt == 4'd3) begin
          state <= S_GAP;
          cnt   <= '0;
        end else cnt <= cnt + 1'b1;
        S_GAP: if (cnt == 4'(`ETH_IFG - 1)) state <= S_IDLE;
          else cnt <= cnt + 1'b1;
        default: state <= S_IDLE;
      endcase
    end
  end

  // Length and header captured at send, header shifted out MSB first
  always_ff @(posedge clk) begin
    if (state == S_IDLE && snd) begin
      len    <= fifo_count;     // Later writes belong to the next frame
      hdr_sr <= '{dst: req.dst, src: loc_mac, ethertype: req.ethertype};
    end else if (state == S_HDR) begin
      hdr_sr <= eth_mac_pkg::mac_hdr_t'({hdr_sr[103:0], 8'h00});
    end
  end

  a_snd_cts: assert property (@(posedge clk) disable iff (!rst_n) snd |-> cts)
    else $error("eth_tx: send request while not clear to send, ignored");

  // Frame goes out next cycle and never has a gap before the minimum length
  a_min_frame: assert property (@(posedge clk) disable iff (!rst_n)
    (snd && cts) |=> phy.val [*MIN_FRAME])
    else $error("eth_tx: frame shorter than minimum or gapped");

endmodule

`default_nettype wire

//--- eth_rx.sv
`default_nettype none
`include "eth_mac_macros.svh"

module eth_rx (
  input  logic                    clk,
  input  logic                    rst_n,
  input  eth_mac_pkg::phy_t       phy,
  input  logic [47:0]             loc_mac,
  output logic [7:0]              dout,
  output logic                    vout,
  output logic                    done,
  output eth_mac_pkg::rx_status_t status
);

  typedef enum logic [2:0] {S_HUNT, S_HDR, S_DATA, S_DROP, S_DONE} state_t;

  state_t                state;
  logic [3:0]            cnt;
  eth_mac_pkg::mac_hdr_t hdr_sr;
  eth_mac_pkg::mac_hdr_t hdr_nxt;
  logic [3:0][7:0]       dly;       // FCS holdback, dly[3] oldest
  logic [3:0]            dly_v;
  logic [31:0]           crc;
  logic                  crc_en;
  logic                  dst_bcast;
  logic                  dst_hit;

  eth_crc32 u_crc (
    .clk   (clk),
    .rst_n (rst_n),
    .clr   (state == S_HUNT),
    .en    (crc_en),
    .din   (phy.dat),
    .crc   (crc)
  );

  // SFD is not covered by the FCS
  assign crc_en = phy.val && ((state == S_HDR) || (state == S_DATA));

  assign hdr_nxt   = eth_mac_pkg::mac_hdr_t'({hdr_sr[103:0], phy.dat});
  assign dst_bcast = (hdr_nxt.dst == `ETH_BCAST);
  assign dst_hit   = dst_bcast || (hdr_nxt.dst == loc_mac); // Valid on last header byte

  //////////////////////////////////////////////////
  // Parser FSM
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= S_HUNT;
      cnt   <= '0;
      dly_v <= '0;
      vout  <= 1'b0;
      done  <= 1'b0;
    end else begin
      vout <= 1'b0;
      done <= 1'b0;
      case (state)
        S_HUNT: if (phy.val && phy.dat == `ETH_SFD) begin
          state <= S_HDR;
          cnt   <= '0;
        end
        S_HDR: begin
          if (!phy.val) begin
            state <= S_HUNT;              // Runt, no report
          end else if (cnt == 4'd13) begin
            state <= dst_hit ? S_DATA : S_DROP;
            dly_v <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (phy.val) begin
            dly_v <= {dly_v[2:0], 1'b1};
            vout  <= dly_v[3];            // Only bytes with four behind them
          end else begin
            state <= S_DONE;
          end
        end
        S_DROP: if (!phy.val) state <= S_HUNT;
        S_DONE: begin
          done  <= 1'b1;
          state <= S_HUNT;
        end
        default: state <= S_HUNT;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (state == S_HDR && phy.val) hdr_sr <= hdr_nxt;
    if (state == S_HDR && phy.val && cnt == 4'd13) begin
      status.hdr   <= hdr_nxt;
      status.bcast <= dst_bcast;
    end
    if (state == S_DATA && phy.val) begin
      dly  <= {dly[2:0], phy.dat};
      dout <= dly[3];
    end
    if (state == S_DONE) status.fcs_ok <= (crc == `ETH_CRC_RESIDUE); // Register incl. FCS
  end

  // Accepted frame carries at least its four FCS bytes
  a_fcs_present: assert property (@(posedge clk) disable iff (!rst_n)
    (state == S_DATA && !phy.val) |-> dly_v[3])
    else $error("eth_rx: accepted frame ended inside its FCS");

endmodule

`default_nettype wire

//--- eth_mac.sv
`default_nettype none

module eth_mac (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [47:0]             loc_mac,
  // User transmit side
  input  logic [7:0]              tx_din,
  input  logic                    tx_vin,
  input  logic                    tx_snd,
  input  eth_mac_pkg::tx_req_t    tx_req,
  output logic                    cts,
  // PHY
  output eth_mac_pkg::phy_t       phy_tx,
  input  eth_mac_pkg::phy_t       phy_rx,
  // User receive side
  output logic [7:0]              rx_dout,
  output logic                    rx_vout,
  output logic                    rx_done,
  output eth_mac_pkg::rx_status_t rx_status
);

  eth_tx u_tx (
    .clk     (clk),
    .rst_n   (rst_n),
    .din     (tx_din),
    .vin     (tx_vin),
    .snd     (tx_snd),
    .req     (tx_req),
    .loc_mac (loc_mac),   // Also the source address of sent frames
    .cts     (cts),
    .phy     (phy_tx)
  );

  eth_rx u_rx (
    .clk     (clk),
    .rst_n   (rst_n),
    .phy     (phy_rx),
    .loc_mac (loc_mac),
    .dout    (rx_dout),
    .vout    (rx_vout),
    .done    (rx_done),
    .status  (rx_status)
  );

endmodule

`default_nettype wire

//--- eth_mac_tb.sv
`default_nettype none
`include "eth_mac_macros.svh"

module eth_mac_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [47:0] LOC_MAC  = 48'h02_00_5E_10_20_30;
  localparam logic [47:0] FOREIGN  = 48'h02_00_5E_99_88_77;
  localparam int          N_FRAMES = 10;

  logic                    clk;
  logic                    rst_n;
  logic [7:0]              tx_din;
  logic                    tx_vin;
  logic                    tx_snd;
  eth_mac_pkg::tx_req_t    tx_req;
  logic                    cts;
  eth_mac_pkg::phy_t       phy_tx;
  eth_mac_pkg::phy_t       phy_rx;
  eth_mac_pkg::phy_t       link_q;        // Link register stage
  logic [7:0]              rx_dout;
  logic                    rx_vout;
  logic                    rx_done;
  eth_mac_pkg::rx_status_t rx_status;
  eth_mac_pkg::rx_status_t exp_status;

  logic [31:0] seed = 32'h76ae2fba;
  int          len_tab [N_FRAMES];
  logic [7:0]  exp_q [$];                 // Payload as the receiver should see it
  logic [7:0]  exp_byte = 8'h00;
  logic        exp_have = 1'b0;
  int          err_cnt = 0;
  int          err_mark = 0;
  int          n_tests = 0;
  int          done_cnt = 0;
  int          done_exp = 0;
  int          tx_run = 0;
  int          exp_tx_len = 0;
  int          link_pos = 0;
  int          corrupt_pos = -1;
  string       test_name = "reset";

  eth_mac u_eth_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .loc_mac   (LOC_MAC),
    .tx_din    (tx_din),
    .tx_vin    (tx_vin),
    .tx_snd    (tx_snd),
    .tx_req    (tx_req),
    .cts       (cts),
    .phy_tx    (phy_tx),
    .phy_rx    (phy_rx),
    .rx_dout   (rx_dout),
    .rx_vout   (rx_vout),
    .rx_done   (rx_done),
    .rx_status (rx_status)
  );

  always #20 clk = ~clk;

  //////////////////////////////////////////////////
  // Loopback link and receive monitor
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    #2;
    phy_rx = link_q;
    link_q = phy_tx;
    if (phy_tx.val) begin
      if (link_pos == corrupt_pos) link_q.dat = link_q.dat ^ 8'h01; // Single bit error
      link_pos++;
      tx_run++;
    end else begin
      link_pos = 0;
    end
    if (rx_vout) begin
      exp_have = (exp_q.size() > 0);
      if (exp_have) exp_byte = exp_q.pop_front();
    end
    if (rx_done) done_cnt++;
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_rx_known: assert property (@(posedge clk) disable iff (!rst_n) rx_vout |-> exp_have)
    else begin
      err_cnt++;
      $display("Unexpected rx payload byte in test %s", test_name);
    end

  a_rx_byte: assert property (@(posedge clk) disable iff (!rst_n)
    (rx_vout && exp_have) |-> rx_dout == exp_byte)
    else begin
      err_cnt++;
      $display("FAILED %s: rx byte expected %02h actual %02h",
               test_name, exp_byte, $sampled(rx_dout));
    end

  // Five cycles from link to user side
  a_rx_delay: assert property (@(posedge clk) disable iff (!rst_n)
    rx_vout |-> $past(phy_rx.val, 5) && rx_dout == $past(phy_rx.dat, 5))
    else begin
      err_cnt++;
      $display("Rx byte not five cycles behind the link in test %s", test_name);
    end

  a_done_expected: assert property (@(posedge clk) disable iff (!rst_n)
    rx_done |-> done_cnt <= done_exp)
    else begin
      err_cnt++;
      $display("Rx_done for a frame that should be dropped in test %s", test_name);
    end

  a_done_delay: assert property (@(posedge clk) disable iff (!rst_n)
    rx_done |-> $past(phy_rx.val, 3) && !$past(phy_rx.val, 2))
    else begin
      err_cnt++;
      $display("Rx_done not two cycles after link idle in test %s", test_name);
    end

  a_status: assert property (@(posedge clk) disable iff (!rst_n)
    rx_done |-> rx_status == exp_status)
    else begin
      err_cnt++;
      $display("FAILED %s: status expected %h actual %h",
               test_name, exp_status, $sampled(rx_status));
    end

  a_tx_len: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(phy_tx.val) |-> tx_run == exp_tx_len)
    else begin
      err_cnt++;
      $display("FAILED %s: tx frame cycles expected %0d actual %0d",
               test_name, exp_tx_len, tx_run);
    end

  a_ifg: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cts) |-> $past(phy_tx.val, `ETH_IFG + 1) && !$past(phy_tx.val, `ETH_IFG))
    else begin
      err_cnt++;
      $display("Cts did not return after the interframe gap in test %s", test_name);
    end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic int next_rand();
    seed = lcg(seed);
    return int'(seed[30:8]);
  endfunction

  // Fill the FIFO, flip marks the payload byte the link will corrupt
  task automatic load_payload(input int n, input logic [47:0] dst, input int flip);
    logic [7:0] b;
    logic       deliver;
    int         i;
    deliver = (dst == LOC_MAC) || (dst == `ETH_BCAST);
    for (i = 0; i < n; i++) begin
      b = 8'(next_rand());
      tx_din = b;
      tx_vin = 1'b1;
      if (deliver) exp_q.push_back((i == flip) ? b ^ 8'h01 : b);
      step();
    end
    tx_vin = 1'b0;
    if (deliver) begin
      for (i = n; i < `ETH_MIN_PAYLOAD; i++) exp_q.push_back(8'h00); // Pad bytes
    end
  endtask

  task automatic send_frame(input int n, input logic [47:0] dst, input int flip);
    logic [15:0] etype;
    etype = 16'(next_rand());
    exp_status.hdr    = '{dst: dst, src: LOC_MAC, ethertype: etype};
    exp_status.fcs_ok = (flip < 0);
    exp_status.bcast  = (dst == `ETH_BCAST);
    exp_tx_len  = `ETH_PREAMBLE_LEN + 14 + ((n > `ETH_MIN_PAYLOAD) ? n : `ETH_MIN_PAYLOAD) + 4;
    corrupt_pos = (flip < 0) ? -1 : `ETH_PREAMBLE_LEN + 14 + flip;
    tx_run = 0;
    if (dst == LOC_MAC || dst == `ETH_BCAST) done_exp++;
    tx_req = '{dst: dst, ethertype: etype};
    tx_snd = 1'b1;
    step();
    tx_snd = 1'b0;
  endtask

  task automatic wait_frame(input logic drained);
    while (!cts) step();
    assert (done_cnt == done_exp) else begin
      err_cnt++;
      $display("FAILED %s: rx_done count expected %0d actual %0d",
               test_name, done_exp, done_cnt);
    end
    if (drained) begin
      assert (exp_q.size() == 0) else begin
        err_cnt++;
        $display("%0d payload bytes never arrived in test %s", exp_q.size(), test_name);
      end
    end
  endtask

  task automatic run_frame(input int n, input logic [47:0] dst, input int flip);
    load_payload(n, dst, flip);
    send_frame(n, dst, flip);
    wait_frame(1'b1);
  endtask

  task automatic end_test();
    n_tests++;
    $display("%-10s %s", test_name, (err_cnt == err_mark) ? "ok" : "errors");
    err_mark = err_cnt;
  endtask

  initial begin
    int i;
    clk        = 1'b0;
    rst_n      = 1'b0;
    tx_din     = 8'h00;
    tx_vin     = 1'b0;
    tx_snd     = 1'b0;
    tx_req     = '0;
    phy_rx     = '0;
    link_q     = '0;
    exp_status = '0;
    for (i = 0; i < N_FRAMES; i++) begin
      len_tab[i] = (i == 3 || i == 4) ? 1 + next_rand() % 45 : 1 + next_rand() % 100;
    end
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    assert (cts && !phy_tx.val && !rx_vout && !rx_done) else begin
      err_cnt++;
      $display("Outputs not idle after reset");
    end
    end_test();

    test_name = "unicast";
    for (i = 0; i < 3; i++) run_frame(len_tab[i], LOC_MAC, -1);
    end_test();

    test_name = "padding";
    run_frame(len_tab[3], LOC_MAC, -1);
    run_frame(len_tab[4], LOC_MAC, -1);
    end_test();

    test_name = "filter";
    run_frame(len_tab[5], FOREIGN, -1);
    run_frame(len_tab[6], `ETH_BCAST, -1);
    end_test();

    test_name = "fcs_error";
    run_frame(len_tab[7], LOC_MAC, next_rand() % len_tab[7]);
    end_test();

    // Second payload goes in while the first frame is on the wire
    test_name = "overlap";
    load_payload(len_tab[8], LOC_MAC, -1);
    send_frame(len_tab[8], LOC_MAC, -1);
    load_payload(len_tab[9], LOC_MAC, -1);
    wait_frame(1'b0);
    send_frame(len_tab[9], LOC_MAC, -1);
    wait_frame(1'b1);
    end_test();

    $display("%0d tests, %0d errors", n_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Budget per frame is twice its length plus gap and slack
  initial begin
    int budget;
    @(posedge rst_n);
    budget = 0;
    foreach (len_tab[i]) begin
      budget += 2 * (`ETH_PREAMBLE_LEN + 18 + ((len_tab[i] > `ETH_MIN_PAYLOAD) ?
                     len_tab[i] : `ETH_MIN_PAYLOAD) + `ETH_IFG + 20);
    end
    repeat (budget) @(posedge clk);
    $display("Timeout after %0d cycles, the tests did not finish", budget);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- eth_mac.f
+incdir+.
eth_mac_pkg.sv
eth_crc32.sv
eth_tx_fifo.sv
eth_tx.sv
eth_rx.sv
eth_mac.sv
eth_mac_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module eth_mac_tb -f eth_mac.f -o eth_mac_sim \
  || exit 1
./obj_dir/eth_mac_sim > sim.log 2>&1
cat sim.log
grep -q "Regression failed" sim.log && exit 1
grep -q "Regression passed" sim.log || exit 1
exit 0
